// File: verilog/memio_pkg.sv
/*
  memio request types
  read/write access types, the request bundle presented with enable
  and the two memory-mapped I/O addresses
*/
package memio_pkg;

  // load width and extension, signed types sign-extend
  typedef enum logic [2:0] {
    rd_none,
    rd_byte,
    rd_half,
    rd_word,
    rd_byte_u,  // zero-extended byte
    rd_half_u   // zero-extended half
  } read_type_e;

  // store width, none for reads
  typedef enum logic [1:0] {
    wr_none,
    wr_byte,
    wr_half,
    wr_word
  } write_type_e;

  // one request, held while enable pulses
  typedef struct packed {
    read_type_e  read_type;
    write_type_e write_type;
    logic [31:0] address;  // byte address, naturally aligned
    logic [31:0] data;     // store data in the low lanes
  } ramio_req_t;

  // ---------------------------------------------------------------------------
  // I/O map, everything else is ram
  // ---------------------------------------------------------------------------
  localparam logic [31:0] addr_led      = 32'hffff_ffff;  // 4 leds, active low
  localparam logic [31:0] addr_uart_out = 32'hffff_fffe;  // serial byte out

endpackage

// File: verilog/burst_pkg.sv
/*
  burst interface types
  command between the cache and the burst memory, one line per burst
*/
package burst_pkg;

  // words per cache line, also beats per burst
  localparam int burst_words = 8;

  typedef enum logic {
    burst_read  = 1'b0,
    burst_write = 1'b1
  } burst_cmd_e;

  // command word, sent with a one cycle cmd_en
  typedef struct packed {
    burst_cmd_e  cmd;
    logic [20:0] addr;  // word address of first word in line
  } burst_cmd_t;

endpackage

// File: verilog/uart_tx.sv
/*
  serial transmitter
  8N1 frame, start bit, 8 data bits lsb first, stop bit
*/
`timescale 1ns/10ps

module uart_tx #(
  parameter int ClockFrequencyHz = 27_000_000,
  parameter int BaudRate         = 115_200
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       uart_tx
);
  localparam int BitCycles = ClockFrequencyHz / BaudRate;
  localparam int CntBits   = $clog2(BitCycles + 1);

  logic [CntBits-1:0] bit_cnt;    // clocks left in current bit
  logic [3:0]         bits_left;  // bits after the current one
  logic [9:0]         frame;      // stop, data, start

  assign uart_tx = tx_busy ? frame[0] : 1'b1;  // idle high

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_busy   <= 1'b0;
      bit_cnt   <= '0;
      bits_left <= '0;
    end else if (!tx_busy) begin
      if (start) begin
        tx_busy   <= 1'b1;
        bit_cnt   <= CntBits'(BitCycles - 1);
        bits_left <= 4'd9;
      end
    end else if (bit_cnt != 0) begin
      bit_cnt <= bit_cnt - 1'b1;
    end else if (bits_left == 0) begin
      tx_busy <= 1'b0;  // stop bit done
    end else begin
      bit_cnt   <= CntBits'(BitCycles - 1);
      bits_left <= bits_left - 1'b1;
    end
  end

  // shift out at each bit boundary
  always_ff @(posedge clk) begin
    if (start && !tx_busy) frame <= {1'b1, tx_byte, 1'b0};
    else if (tx_busy && bit_cnt == 0) frame <= {1'b1, frame[9:1]};
  end

endmodule

// File: verilog/burst_ram.sv
/*
  burst memory
  block ram answering line-sized read and write bursts, command acknowledged
  two cycles after cmd_en, beats follow on consecutive cycles
*/
`timescale 1ns/10ps

module burst_ram #(
  parameter int RamAddressBitWidth = 12
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_en,
  input  burst_pkg::burst_cmd_t cmd,
  output logic                  cmd_ack,
  output logic [31:0]           rd_data,
  output logic                  rd_valid,
  input  logic [31:0]           wr_data
);
  import burst_pkg::*;

  localparam int Words    = 2 ** RamAddressBitWidth;
  localparam int BeatBits = $clog2(burst_words);
  localparam logic [BeatBits-1:0] LastBeat = BeatBits'(burst_words - 1);

  logic [31:0] mem [Words];

  burst_cmd_t                             cmd_q;
  logic                                   ack_wait;  // first ack delay stage
  logic                                   run;       // beats in progress
  logic [BeatBits-1:0]                    beat;
  logic [BeatBits-1:0]                    rd_beat;   // word fetched for next cycle
  logic [RamAddressBitWidth-BeatBits-1:0] base;      // line number

  assign base     = cmd_q.addr[RamAddressBitWidth-1:BeatBits];
  assign rd_beat  = run ? beat + 1'b1 : '0;  // prefetch one ahead
  assign rd_valid = run && cmd_q.cmd == burst_read;

  initial begin
    for (int i = 0; i < Words; i++) mem[i] = '0;
  end

  // ack delay and beat counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_wait <= 1'b0;
      cmd_ack  <= 1'b0;
      run      <= 1'b0;
      beat     <= '0;
    end else begin
      ack_wait <= cmd_en;
      cmd_ack  <= ack_wait;
      if (cmd_ack) begin
        run  <= 1'b1;
        beat <= '0;
      end else if (run) begin
        beat <= beat + 1'b1;
        if (beat == LastBeat) run <= 1'b0;
      end
    end
  end

  // memory port
  always_ff @(posedge clk) begin
    if (cmd_en) cmd_q <= cmd;
    if (run && cmd_q.cmd == burst_write) mem[{base, beat}] <= wr_data;
    rd_data <= mem[{base, rd_beat}];
  end

endmodule

// File: verilog/cache.sv
/*
  direct-mapped write-back cache
  lines of 8 words, hits answer in the request cycle, misses write back a
  dirty victim and refill the line by burst before completing
*/
`timescale 1ns/10ps

module cache #(
  parameter int RamAddressBitWidth     = 12,
  parameter int CacheLineIndexBitWidth = 1
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cache_enable,
  input  logic [RamAddressBitWidth-1:0] word_addr,
  input  logic [31:0]                   wr_word,
  input  logic [3:0]                    byte_mask,
  input  logic                          write,
  output logic                          cache_done,
  output logic [31:0]                   rd_word,
  output logic                          cmd_en,
  output burst_pkg::burst_cmd_t         cmd,
  input  logic                          cmd_ack,
  input  logic [31:0]                   rd_data,
  input  logic                          rd_valid,
  output logic [31:0]                   wr_data
);
  import burst_pkg::*;

  localparam int Lines    = 2 ** CacheLineIndexBitWidth;
  localparam int BeatBits = $clog2(burst_words);
  localparam int TagBits  = RamAddressBitWidth - CacheLineIndexBitWidth - BeatBits;
  localparam logic [BeatBits-1:0] LastBeat = BeatBits'(burst_words - 1);

  typedef enum logic [1:0] {
    lookup,
    evict,  // writing victim back
    fill    // reading line in
  } state_e;

  state_e state;

  // line storage
  logic [31:0]        line_data [Lines][burst_words];
  logic [TagBits-1:0] line_tag  [Lines];
  logic [Lines-1:0]   line_valid;
  logic [Lines-1:0]   line_dirty;

  logic                pending;  // miss in progress, request still owed
  logic                wr_run;   // write beats running
  logic [BeatBits-1:0] beat;

  // address split
  logic [TagBits-1:0]                tag;
  logic [CacheLineIndexBitWidth-1:0] index;
  logic [BeatBits-1:0]               offset;

  logic                          active, hit;
  logic [RamAddressBitWidth-1:0] line_addr;

  assign {tag, index, offset} = word_addr;  // held by ramio through the miss

  assign active     = cache_enable | pending;
  assign hit        = line_valid[index] && line_tag[index] == tag;
  assign cache_done = state == lookup && active && hit;
  assign cmd_en     = state == lookup && active && !hit;  // one cycle, state leaves lookup
  assign rd_word    = line_data[index][offset];
  assign wr_data    = line_data[index][beat];  // victim word per beat

  // victim line if dirty, else the requested line
  assign line_addr = line_dirty[index] ? {line_tag[index], index, {BeatBits{1'b0}}}
                                       : {tag, index, {BeatBits{1'b0}}};

  always_comb begin
    cmd                                = '0;
    cmd.cmd                            = line_dirty[index] ? burst_write : burst_read;
    cmd.addr[RamAddressBitWidth-1:0]   = line_addr;
  end

  // ---------------------------------------------------------------------------
  // miss handling
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= lookup;
      pending    <= 1'b0;
      wr_run     <= 1'b0;
      beat       <= '0;
      line_valid <= '0;  // all lines invalid
      line_dirty <= '0;
    end else begin
      case (state)
        lookup: begin
          if (cmd_en) begin
            pending <= 1'b1;
            state   <= line_dirty[index] ? evict : fill;
          end else if (cache_done) begin
            pending <= 1'b0;
            if (write) line_dirty[index] <= 1'b1;
          end
        end
        evict: begin
          if (cmd_ack) wr_run <= 1'b1;  // beats start next cycle
          if (wr_run) begin
            beat <= beat + 1'b1;  // wraps back to 0
            if (beat == LastBeat) begin
              wr_run            <= 1'b0;
              line_dirty[index] <= 1'b0;
              state             <= lookup;  // now clean, lookup issues the fill
            end
          end
        end
        fill: begin
          if (rd_valid) begin
            beat <= beat + 1'b1;
            if (beat == LastBeat) begin
              line_valid[index] <= 1'b1;
              state             <= lookup;  // hits next cycle
            end
          end
        end
        default: state <= lookup;
      endcase
    end
  end

  // line data and tags
  always_ff @(posedge clk) begin
    if (state == fill && rd_valid) begin
      line_data[index][beat] <= rd_data;
      if (beat == LastBeat) line_tag[index] <= tag;
    end else if (cache_done && write) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_mask[i]) line_data[index][offset][8*i +: 8] <= wr_word[8*i +: 8];
      end
    end
  end

endmodule

// File: verilog/ramio.sv
/*
  ram/io unit
  decodes each request to ram, led or serial out, aligns byte and half
  accesses onto cache words and sequences the request to completion
*/
`timescale 1ns/10ps

module ramio #(
  parameter int RamAddressBitWidth     = 12,
  parameter int CacheLineIndexBitWidth = 1,
  parameter int ClockFrequencyHz       = 27_000_000,
  parameter int BaudRate               = 115_200
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  memio_pkg::ramio_req_t req,
  output logic [31:0]           data_out,
  output logic                  data_out_ready,
  output logic                  busy,
  output logic [3:0]            led,
  output logic                  uart_tx,
  output logic                  cmd_en,
  output burst_pkg::burst_cmd_t cmd,
  input  logic                  cmd_ack,
  input  logic [31:0]           rd_data,
  input  logic                  rd_valid,
  output logic [31:0]           wr_data
);
  import memio_pkg::*;

  typedef enum logic [1:0] {
    idle,
    ram_wait,   // cache working
    uart_wait   // waiting on transmitter, led writes pass straight through
  } state_e;

  state_e state;

  // request to cache, registered at enable
  logic                          cache_enable;
  logic [RamAddressBitWidth-1:0] word_addr;
  logic [31:0]                   wr_word;
  logic [3:0]                    byte_mask;
  logic                          write;
  logic                          cache_done;
  logic [31:0]                   rd_word;

  read_type_e rd_type_q;  // kept for load alignment
  logic [1:0] lane_q;     // byte offset within word

  logic        is_write, is_led, is_uart;
  logic        tx_start, tx_busy;
  logic [31:0] lane_word, load_word;
  logic [31:0] store_word;
  logic [3:0]  store_mask;

  // ---------------------------------------------------------------------------
  // decode
  // ---------------------------------------------------------------------------
  assign is_write = req.write_type != wr_none;
  assign is_led   = is_write && req.address == addr_led;
  assign is_uart  = is_write && req.address == addr_uart_out;
  assign tx_start = state == idle && enable && is_uart;  // tx_busy up next cycle

  // store lanes, data replicated so the mask picks the lane
  always_comb begin
    case (req.write_type)
      wr_byte: begin
        store_mask = 4'b0001 << req.address[1:0];
        store_word = {4{req.data[7:0]}};
      end
      wr_half: begin
        store_mask = req.address[1] ? 4'b1100 : 4'b0011;
        store_word = {2{req.data[15:0]}};
      end
      default: begin
        store_mask = 4'b1111;
        store_word = req.data;
      end
    endcase
  end

  // load shift and extend
  always_comb begin
    lane_word = rd_word >> {lane_q, 3'b000};
    case (rd_type_q)
      rd_byte:   load_word = {{24{lane_word[7]}}, lane_word[7:0]};
      rd_half:   load_word = {{16{lane_word[15]}}, lane_word[15:0]};
      rd_byte_u: load_word = {24'h0, lane_word[7:0]};
      rd_half_u: load_word = {16'h0, lane_word[15:0]};
      default:   load_word = rd_word;
    endcase
  end

  // ---------------------------------------------------------------------------
  // request sequencing
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state          <= idle;
      busy           <= 1'b0;
      data_out_ready <= 1'b0;
      cache_enable   <= 1'b0;
      led            <= 4'hf;  // leds off
    end else begin
      data_out_ready <= 1'b0;  // single cycle strobes
      cache_enable   <= 1'b0;
      case (state)
        idle: begin
          if (enable) begin
            busy <= 1'b1;
            if (is_led) begin
              led   <= ~req.data[3:0];  // active low
              state <= uart_wait;       // transmitter idle, ends next cycle
            end else if (is_uart) begin
              state <= uart_wait;
            end else begin
              cache_enable <= 1'b1;
              state        <= ram_wait;
            end
          end
        end
        ram_wait: begin
          if (cache_done) begin
            busy           <= 1'b0;
            data_out_ready <= rd_type_q != rd_none && !write;
            state          <= idle;
          end
        end
        uart_wait: begin
          if (!tx_busy) begin  // stop bit sent
            busy  <= 1'b0;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // request and load data registers
  always_ff @(posedge clk) begin
    if (state == idle && enable) begin
      word_addr <= req.address[RamAddressBitWidth+1:2];
      wr_word   <= store_word;
      byte_mask <= store_mask;
      write     <= is_write;
      rd_type_q <= req.read_type;
      lane_q    <= req.address[1:0];
    end
    if (state == ram_wait && cache_done) data_out <= load_word;
  end

  // ---------------------------------------------------------------------------
  // cache and transmitter
  // ---------------------------------------------------------------------------
  cache #(
    .RamAddressBitWidth    (RamAddressBitWidth),
    .CacheLineIndexBitWidth(CacheLineIndexBitWidth)
  ) i_cache (
    .clk,
    .rst_n,
    .cache_enable,
    .word_addr,
    .wr_word,
    .byte_mask,
    .write,
    .cache_done,
    .rd_word,
    .cmd_en,
    .cmd,
    .cmd_ack,
    .rd_data,
    .rd_valid,
    .wr_data
  );

  uart_tx #(
    .ClockFrequencyHz(ClockFrequencyHz),
    .BaudRate        (BaudRate)
  ) i_uart_tx (
    .clk,
    .rst_n,
    .start  (tx_start),
    .tx_byte(req.data[7:0]),
    .tx_busy,
    .uart_tx
  );

endmodule

// File: verilog/memio_top.sv
/*
  memio top level
  ram/io unit joined to the block ram burst memory, all parameters set here
*/
`timescale 1ns/10ps

module memio_top #(
  parameter int RamAddressBitWidth     = 12,          // burst_ram words, log2
  parameter int CacheLineIndexBitWidth = 1,           // 2 lines
  parameter int ClockFrequencyHz       = 27_000_000,
  parameter int BaudRate               = 115_200
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  memio_pkg::ramio_req_t req,
  output logic [31:0]           data_out,
  output logic                  data_out_ready,
  output logic                  busy,
  output logic [3:0]            led,
  output logic                  uart_tx
);
  import burst_pkg::*;

  // cache <-> memory burst wires
  logic        cmd_en;
  burst_cmd_t  cmd;
  logic        cmd_ack;
  logic [31:0] rd_data;
  logic        rd_valid;
  logic [31:0] wr_data;

  // ---------------------------------------------------------------------------
  // ram/io unit
  // ---------------------------------------------------------------------------
  ramio #(
    .RamAddressBitWidth    (RamAddressBitWidth),
    .CacheLineIndexBitWidth(CacheLineIndexBitWidth),
    .ClockFrequencyHz      (ClockFrequencyHz),
    .BaudRate              (BaudRate)
  ) i_ramio (
    .clk,
    .rst_n,
    .enable,
    .req,
    .data_out,
    .data_out_ready,
    .busy,
    .led,
    .uart_tx,
    .cmd_en,
    .cmd,
    .cmd_ack,
    .rd_data,
    .rd_valid,
    .wr_data
  );

  // ---------------------------------------------------------------------------
  // burst memory, stands in for the sdram controller
  // ---------------------------------------------------------------------------
  burst_ram #(
    .RamAddressBitWidth(RamAddressBitWidth)
  ) i_burst_ram (
    .clk,
    .rst_n,
    .cmd_en,
    .cmd,
    .cmd_ack,
    .rd_data,
    .rd_valid,
    .wr_data
  );

endmodule

// File: tb/memio_tb.sv
/*
  memio testbench
  acts as the core: loads test steps from a file, drives each request through
  the enable/busy handshake, decodes the serial line and checks every result
*/
`timescale 1ns/10ps

module memio_tb;
  import memio_pkg::*;

  localparam int ClockFrequencyHz = 25_000_000;
  localparam int BaudRate         = 2_500_000;
  localparam int BitClocks        = 10;   // 2.5 Mbaud from a 25 MHz clock
  localparam int CyclesPerStep    = 300;  // serial byte steps are the longest at about 106 cycles

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_led,   // write to led register
    op_uart   // write to serial out
  } op_e;

  // one line of the tests file
  typedef struct packed {
    op_e         op;
    read_type_e  read_type;
    write_type_e write_type;
    logic [31:0] address;
    logic [31:0] data;
    logic [31:0] expected;  // data_out, led or serial byte
  } test_step_t;

  logic        clk;
  logic        rst_n;
  logic        enable;
  ramio_req_t  req;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic [3:0]  led;
  logic        uart_tx;

  test_step_t steps [$];
  int         cycle_count;
  int         cycle_limit;   // 0 until the tests are loaded
  int         current_step;  // counted from 1 in error lines

  memio_top #(
    .ClockFrequencyHz(ClockFrequencyHz),
    .BaudRate        (BaudRate)
  ) i_memio_top (
    .clk,
    .rst_n,
    .enable,
    .req,
    .data_out,
    .data_out_ready,
    .busy,
    .led,
    .uart_tx
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  // ---------------------------------------------------------------------------
  // run limit
  // ---------------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      abort_run($sformatf("timeout: DUT still running after %0d cycles", cycle_count));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h (step %0d)",
                          name, got, exp, current_step));
  endtask

  task automatic check_led(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] led: got 0x%01h, expected 0x%01h (step %0d)",
                          got, exp, current_step));
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] uart_tx: got 0x%02h, expected 0x%02h (step %0d)",
                          got, exp, current_step));
  endtask

  // ---------------------------------------------------------------------------
  // tests file
  // ---------------------------------------------------------------------------
  function automatic read_type_e parse_read_type(input logic [63:0] name);
    case (name)
      "byte":   return rd_byte;
      "half":   return rd_half;
      "word":   return rd_word;
      "byte_u": return rd_byte_u;
      "half_u": return rd_half_u;
      default:  return rd_none;  // unknown name
    endcase
  endfunction

  function automatic write_type_e parse_write_type(input logic [63:0] name);
    case (name)
      "byte":  return wr_byte;
      "half":  return wr_half;
      "word":  return wr_word;
      default: return wr_none;
    endcase
  endfunction

  task automatic load_tests();
    int               fd;
    int               code;
    logic             bad;
    logic [63:0]      op_name;
    logic [63:0]      type_name;
    logic [8*128-1:0] rest;
    test_step_t       step;
    fd = $fopen("tb/memio_tests.txt", "r");
    if (fd == 0) abort_run("cannot open tb/memio_tests.txt");
    while (!$feof(fd)) begin
      op_name = '0;
      code    = $fscanf(fd, "%s", op_name);
      if (code == 1 && op_name == "#") begin
        code = $fgets(rest, fd);  // comment line
      end else if (code == 1) begin
        step = '0;
        code = $fscanf(fd, "%s %h %h %h", type_name, step.address, step.data,
                       step.expected);
        bad  = code != 4;
        case (op_name)
          "read":  step.op = op_read;
          "write": step.op = op_write;
          "led":   step.op = op_led;
          "uart":  step.op = op_uart;
          default: bad = 1'b1;
        endcase
        if (step.op == op_read) begin
          step.read_type = parse_read_type(type_name);
          bad            = bad || step.read_type == rd_none;
        end else begin
          step.write_type = parse_write_type(type_name);
          bad             = bad || step.write_type == wr_none;
        end
        if (bad) abort_run($sformatf("malformed line %0d in the tests file", steps.size() + 1));
        else steps.push_back(step);
      end
    end
    $fclose(fd);
    if (steps.size() == 0) abort_run("tests file holds no test steps");
  endtask

  // ---------------------------------------------------------------------------
  // request handshake and serial decode
  // ---------------------------------------------------------------------------
  task automatic drive_request(input test_step_t step, output int ready_count);
    ready_count = 0;
    @(posedge clk);
    req.read_type  <= step.read_type;
    req.write_type <= step.write_type;
    req.address    <= step.address;
    req.data       <= step.data;
    enable         <= 1'b1;
    @(posedge clk);  // DUT takes the request here
    enable <= 1'b0;
    @(posedge clk);
    if (!busy) abort_run("busy did not rise on the cycle after enable");
    while (busy) begin
      @(posedge clk);
      if (data_out_ready) ready_count++;
    end
  endtask

  // samples each bit at its middle by counting clocks from the start edge
  task automatic receive_serial_byte(output logic [7:0] rx_byte, output logic framed);
    logic start_bit;
    logic stop_bit;
    @(negedge uart_tx);
    repeat (BitClocks / 2) @(posedge clk);
    start_bit = uart_tx;
    for (int i = 0; i < 8; i++) begin
      repeat (BitClocks) @(posedge clk);
      rx_byte[i] = uart_tx;  // lsb first
    end
    repeat (BitClocks) @(posedge clk);
    stop_bit = uart_tx;
    framed   = !start_bit && stop_bit;
  endtask

  task automatic run_step(input test_step_t step);
    int         ready_count;
    logic [7:0] rx_byte;
    logic       framed;
    if (step.op == op_uart) begin
      fork
        receive_serial_byte(rx_byte, framed);
        drive_request(step, ready_count);
      join
    end else begin
      drive_request(step, ready_count);
    end
    case (step.op)
      op_read: begin
        if (ready_count != 1 || !data_out_ready)
          abort_run($sformatf("step %0d: read did not end with one data_out_ready pulse",
                              current_step));
        else begin
          check_word("data_out", data_out, step.expected);
          @(posedge clk);  // strobe must be gone one cycle later
          if (data_out_ready)
            abort_run($sformatf("step %0d: data_out_ready high for more than one cycle",
                                current_step));
        end
      end
      op_led: check_led(led, step.expected[3:0]);
      op_uart: begin
        if (!framed)
          abort_run($sformatf("step %0d: bad start or stop bit on uart_tx", current_step));
        else check_byte(rx_byte, step.expected[7:0]);
      end
      default: begin
        if (ready_count != 0)
          abort_run($sformatf("step %0d: write raised data_out_ready", current_step));
      end
    endcase
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial begin
    cycle_count  = 0;
    cycle_limit  = 0;
    current_step = 0;
    rst_n        = 1'b0;
    enable       = 1'b0;
    req          = '0;
    load_tests();
    cycle_limit = steps.size() * CyclesPerStep + 100;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_led(led, 4'hf);  // active low leds all off
    for (int i = 0; i < steps.size(); i++) begin
      current_step = i + 1;
      run_step(steps[i]);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: files.f
verilog/memio_pkg.sv
verilog/burst_pkg.sv
verilog/uart_tx.sv
verilog/burst_ram.sv
verilog/cache.sv
verilog/ramio.sv
verilog/memio_top.sv
tb/memio_tb.sv

// File: tb/memio_tests.txt
# op    type    address   data      expected
# expected is data_out for read, led for led, the serial byte for uart
write   word    00000100  12345678  00000000
read    word    00000100  00000000  12345678
read    word    00000104  00000000  00000000
write   word    00000108  a1b2c3d4  00000000
write   byte    00000109  123456f5  00000000
write   half    0000010a  9abc8e07  00000000
read    word    00000108  00000000  8e07f5d4
read    byte    00000109  00000000  fffffff5
read    byte_u  00000109  00000000  000000f5
read    half    0000010a  00000000  ffff8e07
read    half_u  0000010a  00000000  00008e07
read    byte    0000010b  00000000  ffffff8e
read    half    00000108  00000000  fffff5d4
write   byte    0000010c  0000007a  00000000
read    byte    0000010c  00000000  0000007a
write   word    00000140  cafef00d  00000000
read    word    00000100  00000000  12345678
read    word    00000108  00000000  8e07f5d4
read    word    00000140  00000000  cafef00d
write   word    00000020  0badc0de  00000000
read    word    00000020  00000000  0badc0de
uart    word    fffffffe  000000a5  000000a5
uart    word    fffffffe  0000003c  0000003c
led     word    ffffffff  00000005  0000000a
led     word    ffffffff  123456fc  00000003
